// File: hw/cl_scrub_cfg.svh
`ifndef CL_SCRUB_CFG_SVH
`define CL_SCRUB_CFG_SVH

// ------------------------------------------------------------
// Channel count and scrub walk limits
// ------------------------------------------------------------

// Number of DDR channels with a scrubber
`define CL_NUM_DDR 4

// Only 8 KiB of each memory is walked in simulation
`define CL_SCRB_MAX_ADDR 64'h0000_0000_0000_1FFF

// Burst of 16 beats
`define CL_SCRB_BURST_LEN_MINUS1 15

// Bytes moved per data beat
`define CL_DDR_BEAT_BYTES 64

// ------------------------------------------------------------
// Reset and identification
// ------------------------------------------------------------

// Flops between the raw reset and the two-flop synchronizer
`define CL_RST_PIPE_STAGES 4

// PCI ID words shown when debug readback is off
`define CL_SH_ID0 32'hF000_1D0F
`define CL_SH_ID1 32'h1D51_FEDC

`endif

// File: hw/cl_scrub_pkg.sv
`include "cl_scrub_cfg.svh"

package cl_scrub_pkg;

   // ------------------------------------------------------------
   // Debug memory select
   // ------------------------------------------------------------

   // Values 0 to 3 pick a channel, anything above maps to channel 0
   typedef logic [2:0] mem_sel_t;

   // ------------------------------------------------------------
   // Control word
   // ------------------------------------------------------------

   // Bit 31 debug enable, bits 30:28 debug select,
   // low bits are the per-channel scrub enables
   typedef struct packed {
      logic                     dbg_en;
      mem_sel_t                 dbg_sel;
      logic [27:`CL_NUM_DDR]    rsvd;
      logic [`CL_NUM_DDR-1:0]   scrb_en;
   } ctl_word_t;

   // ------------------------------------------------------------
   // Scrub address
   // ------------------------------------------------------------

   // Halves as they appear on the two ID outputs
   typedef struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
   } scrb_addr_half_t;

   // Counter view for the scrubber, split view for the readback
   typedef union packed {
      logic [63:0]     addr;
      scrb_addr_half_t half;
   } scrb_addr_u;

endpackage

// File: hw/cl_ctl_in.sv
`timescale 1ns/100ps

`include "cl_scrub_cfg.svh"

module cl_ctl_in
   import cl_scrub_pkg::*;
(
   input  logic        clk,
   input  logic        rst_main_n,
   input  logic        flr_assert,
   input  logic [31:0] ctl0,
   output logic        sync_rst_n,
   output logic        flr_done,
   output ctl_word_t   ctl_q
);

   localparam int STAGES = `CL_RST_PIPE_STAGES;

   logic [STAGES-1:0] rst_pipe;
   logic              pipe_rst_n;
   logic              pre_sync_rst_n;
   logic              flr_assert_q;

   // ------------------------------------------------------------
   // Reset synchronizer
   // ------------------------------------------------------------

   // Plain shift pipe on the raw reset, no reset of its own
   always_ff @(posedge clk)
   begin
      rst_pipe <= {rst_pipe[STAGES-2:0], rst_main_n};
   end

   assign pipe_rst_n = rst_pipe[STAGES-1];

   // Assert immediately, release two edges after the pipe
   always_ff @(posedge clk or negedge pipe_rst_n)
   begin
      if (!pipe_rst_n)
      begin
         pre_sync_rst_n <= 1'b0;
         sync_rst_n     <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         sync_rst_n     <= pre_sync_rst_n;
      end
   end

   // ------------------------------------------------------------
   // FLR acknowledge and control word
   // ------------------------------------------------------------

   // One done pulse per registered request cycle
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
         ctl_q <= '0;
      else
         ctl_q <= ctl_word_t'(ctl0);
   end

endmodule

// File: hw/ddr_scrubber.sv
`timescale 1ns/100ps

`include "cl_scrub_cfg.svh"

module ddr_scrubber
   import cl_scrub_pkg::*;
#(
   parameter logic [63:0] MAX_ADDR         = 64'h1FFF,
   parameter int          BURST_LEN_MINUS1 = 15
)
(
   input  logic       clk,
   input  logic       sync_rst_n,
   input  logic       scrb_en,
   input  logic       scrb_awready,
   output logic       scrb_awvalid,
   output scrb_addr_u scrb_awaddr,
   output logic       scrb_done
);

   // Bytes covered by one accepted burst
   localparam logic [63:0] BURST_BYTES =
      64'((BURST_LEN_MINUS1 + 1) * `CL_DDR_BEAT_BYTES);

   logic        burst_acc;
   logic [63:0] next_addr;

   // ------------------------------------------------------------
   // Request side
   // ------------------------------------------------------------

   // One request outstanding at a time, held until accepted
   assign scrb_awvalid = scrb_en && !scrb_done;
   assign burst_acc    = scrb_awvalid && scrb_awready;

   // Address of the burst after the one being accepted
   assign next_addr = scrb_awaddr.addr + BURST_BYTES;

   // ------------------------------------------------------------
   // Address walker
   // ------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         scrb_awaddr.addr <= '0;
         scrb_done        <= 1'b0;
      end
      else if (!scrb_en)
      begin
         // Disabled channel rewinds so the next enable starts at zero
         scrb_awaddr.addr <= '0;
         scrb_done        <= 1'b0;
      end
      else if (burst_acc)
      begin
         scrb_awaddr.addr <= next_addr;
         // Walk ends once the next burst would start past the limit
         if (next_addr > MAX_ADDR)
         begin
            scrb_done <= 1'b1;
         end
      end
   end

endmodule

// File: hw/scrub_id_readback.sv
`timescale 1ns/100ps

`include "cl_scrub_cfg.svh"

module scrub_id_readback
   import cl_scrub_pkg::*;
(
   input  logic        clk,
   input  logic        sync_rst_n,
   input  logic        dbg_en,
   input  mem_sel_t    dbg_sel,
   input  scrb_addr_u  scrb_addr [`CL_NUM_DDR],
   output logic [31:0] id0,
   output logic [31:0] id1
);

   scrb_addr_u sel_addr;

   // ------------------------------------------------------------
   // Channel select
   // ------------------------------------------------------------

   // Channel 0 is the default, so out of range selects land there
   always_comb
   begin
      sel_addr = scrb_addr[0];
      for (int i = 1; i < `CL_NUM_DDR; i++)
      begin
         if (dbg_sel == mem_sel_t'(i))
         begin
            sel_addr = scrb_addr[i];
         end
      end
   end

   // ------------------------------------------------------------
   // ID output registers
   // ------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= '0;
         id1 <= '0;
      end
      else if (dbg_en)
      begin
         // Low half on id0, high half on id1
         id0 <= sel_addr.half.lo;
         id1 <= sel_addr.half.hi;
      end
      else
      begin
         id0 <= `CL_SH_ID0;
         id1 <= `CL_SH_ID1;
      end
   end

endmodule

// File: hw/cl_scrub_top.sv
`timescale 1ns/100ps

`include "cl_scrub_cfg.svh"

module cl_scrub_top
   import cl_scrub_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_main_n,
   input  logic                   flr_assert,
   output logic                   flr_done,
   input  logic [31:0]            ctl0,
   input  logic [`CL_NUM_DDR-1:0] scrb_awready,
   output logic [`CL_NUM_DDR-1:0] scrb_awvalid,
   output scrb_addr_u             scrb_awaddr [`CL_NUM_DDR],
   output logic [`CL_NUM_DDR-1:0] scrb_done,
   output logic [31:0]            id0,
   output logic [31:0]            id1
);

   logic      sync_rst_n;
   ctl_word_t ctl_q;

   // ------------------------------------------------------------
   // Reset, FLR and control register
   // ------------------------------------------------------------

   cl_ctl_in u_ctl_in (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .flr_assert (flr_assert),
      .ctl0       (ctl0),
      .sync_rst_n (sync_rst_n),
      .flr_done   (flr_done),
      .ctl_q      (ctl_q)
   );

   // ------------------------------------------------------------
   // Per-channel scrubbers
   // ------------------------------------------------------------

   // Channels run independently, each on its own enable bit
   for (genvar ch = 0; ch < `CL_NUM_DDR; ch++)
   begin : g_scrub
      ddr_scrubber #(
         .MAX_ADDR         (`CL_SCRB_MAX_ADDR),
         .BURST_LEN_MINUS1 (`CL_SCRB_BURST_LEN_MINUS1)
      ) u_scrubber (
         .clk          (clk),
         .sync_rst_n   (sync_rst_n),
         .scrb_en      (ctl_q.scrb_en[ch]),
         .scrb_awready (scrb_awready[ch]),
         .scrb_awvalid (scrb_awvalid[ch]),
         .scrb_awaddr  (scrb_awaddr[ch]),
         .scrb_done    (scrb_done[ch])
      );
   end

   // ------------------------------------------------------------
   // ID and debug address readback
   // ------------------------------------------------------------

   scrub_id_readback u_id_readback (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .dbg_en     (ctl_q.dbg_en),
      .dbg_sel    (ctl_q.dbg_sel),
      .scrb_addr  (scrb_awaddr),
      .id0        (id0),
      .id1        (id1)
   );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen
#(
   parameter int PERIOD_NS = 100
)
(
   output logic clk
);

   // Free running clock, low at time zero
   initial
   begin
      clk = 1'b0;
   end

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: dv/cl_scrub_properties.sv
`timescale 1ns/100ps

`include "cl_scrub_cfg.svh"

module cl_scrub_properties
   import cl_scrub_pkg::*;
#(
   parameter logic [63:0] MAX_ADDR = `CL_SCRB_MAX_ADDR
)
(
   input logic       clk,
   input logic       sync_rst_n,
   input logic       scrb_en,
   input logic       scrb_awvalid,
   input logic       scrb_awready,
   input scrb_addr_u scrb_awaddr,
   input logic       scrb_done
);

   // ------------------------------------------------------------
   // Burst request handshake
   // ------------------------------------------------------------

   // Stalled request stays up with the same address
   property p_hold_on_stall;
      @(posedge clk) disable iff (!sync_rst_n)
         (scrb_awvalid && !scrb_awready) |=>
            (scrb_awvalid && $stable(scrb_awaddr.addr));
   endproperty

   // Done is sticky while enabled and no further request follows it
   property p_no_valid_when_done;
      @(posedge clk) disable iff (!sync_rst_n)
         (scrb_done && scrb_en) |=> (scrb_done && !scrb_awvalid);
   endproperty

   // Requested burst always starts inside the scrub range
   property p_addr_in_range;
      @(posedge clk) disable iff (!sync_rst_n)
         scrb_awvalid |-> (scrb_awaddr.addr <= MAX_ADDR);
   endproperty

   a_hold_on_stall: assert property (p_hold_on_stall)
      else $error("burst request changed while stalled");

   a_no_valid_when_done: assert property (p_no_valid_when_done)
      else $error("burst request raised after scrub done");

   a_addr_in_range: assert property (p_addr_in_range)
      else $error("burst address beyond the scrub limit");

endmodule

// File: dv/cl_scrub_tb.sv
`timescale 1ns/100ps

`include "cl_scrub_cfg.svh"

module cl_scrub_tb
   import cl_scrub_pkg::*;
();

   localparam int          NCH         = `CL_NUM_DDR;
   localparam logic [63:0] BURST_BYTES =
      64'((`CL_SCRB_BURST_LEN_MINUS1 + 1) * `CL_DDR_BEAT_BYTES);
   localparam int          NUM_BURSTS  = int'((`CL_SCRB_MAX_ADDR + 64'd1) / BURST_BYTES);
   localparam logic [63:0] FINAL_ADDR  = 64'(NUM_BURSTS) * BURST_BYTES;

   // Worst case run length: tests x channels x bursts x stall cycles
   localparam int NUM_TESTS       = 6;
   localparam int MAX_STALL       = 8;
   localparam int WATCHDOG_MARGIN = 464;
   localparam int WATCHDOG_CYCLES =
      NUM_TESTS * NCH * NUM_BURSTS * MAX_STALL + WATCHDOG_MARGIN;
   localparam int WALK_LIMIT      = 300;

   logic             clk;
   logic             rst_main_n;
   logic             flr_assert;
   logic             flr_done_w;
   logic [31:0]      ctl0;
   logic [NCH-1:0]   scrb_awready;
   logic [NCH-1:0]   scrb_awvalid;
   scrb_addr_u       scrb_awaddr [NCH];
   logic [NCH-1:0]   scrb_done;
   logic [31:0]      id0;
   logic [31:0]      id1;

   logic [31:0]      rng_state;
   int               checks;
   int               errors;
   int               test_errors;
   int               tests_run;
   int               tests_bad;

   tb_clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk(clk));

   cl_scrub_top u_cl_scrub_top (
      .clk          (clk),
      .rst_main_n   (rst_main_n),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done_w),
      .ctl0         (ctl0),
      .scrb_awready (scrb_awready),
      .scrb_awvalid (scrb_awvalid),
      .scrb_awaddr  (scrb_awaddr),
      .scrb_done    (scrb_done),
      .id0          (id0),
      .id1          (id1)
   );

   bind ddr_scrubber cl_scrub_properties u_scrub_props (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .scrb_en      (scrb_en),
      .scrb_awvalid (scrb_awvalid),
      .scrb_awready (scrb_awready),
      .scrb_awaddr  (scrb_awaddr),
      .scrb_done    (scrb_done)
   );

   // ------------------------------------------------------------
   // Helpers and compare tasks
   // ------------------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic note_error();
      errors++;
      test_errors++;
   endtask

   task automatic check_addr(input string name, input scrb_addr_u exp, input scrb_addr_u act);
      checks++;
      if (act.addr !== exp.addr)
      begin
         $display("[FAIL] %s: expected 0x%016h, actual 0x%016h", name, exp.addr, act.addr);
         note_error();
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         note_error();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
         note_error();
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("%s: ok", name);
      else
      begin
         tests_bad++;
         $display("%s: %0d error(s)", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic set_ctl(input logic dbg_en, input mem_sel_t sel, input logic [NCH-1:0] mask);
      ctl_word_t w;
      w         = '0;
      w.dbg_en  = dbg_en;
      w.dbg_sel = sel;
      w.scrb_en = mask;
      ctl0      = w;
   endtask

   // Random back-pressure, ready three times out of four
   task automatic draw_ready(input bit stall, output logic ready);
      if (stall)
      begin
         rng_state = xorshift32(rng_state);
         ready     = (rng_state[1:0] != 2'b00);
      end
      else
         ready = 1'b1;
   endtask

   // Follows the enabled channels from address zero until each raises done
   task automatic walk_channels(input string name, input logic [NCH-1:0] mask, input bit stall);
      scrb_addr_u     exp_addr [NCH];
      int             bursts [NCH];
      logic [NCH-1:0] finished;
      logic [NCH-1:0] ready;
      logic           r;
      int             cycles;
      for (int ch = 0; ch < NCH; ch++)
      begin
         exp_addr[ch].addr = '0;
         bursts[ch]        = 0;
      end
      finished = ~mask;
      cycles   = 0;
      while (finished != '1 && cycles < WALK_LIMIT)
      begin
         ready = '0;
         for (int ch = 0; ch < NCH; ch++)
         begin
            if (!mask[ch])
               check_bit(name, 1'b0, scrb_awvalid[ch]);
            else if (!finished[ch] && scrb_done[ch])
            begin
               check_bit(name, 1'b0, scrb_awvalid[ch]);
               check_addr(name, scrb_addr_u'(FINAL_ADDR), scrb_awaddr[ch]);
               if (bursts[ch] != NUM_BURSTS)
               begin
                  $display("%s: channel %0d finished after %0d bursts instead of %0d",
                           name, ch, bursts[ch], NUM_BURSTS);
                  note_error();
               end
               finished[ch] = 1'b1;
            end
            else if (!finished[ch])
            begin
               check_bit(name, 1'b1, scrb_awvalid[ch]);
               check_addr(name, exp_addr[ch], scrb_awaddr[ch]);
               draw_ready(stall, r);
               ready[ch] = r;
               if (r)
               begin
                  bursts[ch]++;
                  exp_addr[ch].addr = exp_addr[ch].addr + BURST_BYTES;
               end
            end
         end
         scrb_awready = ready;
         next_cycle();
         cycles++;
      end
      scrb_awready = '0;
      for (int ch = 0; ch < NCH; ch++)
      begin
         if (!finished[ch])
         begin
            $display("%s: channel %0d never raised done within %0d cycles",
                     name, ch, WALK_LIMIT);
            note_error();
         end
      end
   endtask

   // Rewinds every channel, then enables the ones in the mask
   task automatic run_scrub(input string name, input logic [NCH-1:0] mask, input bit stall);
      set_ctl(1'b0, 3'd0, '0);
      next_cycle();
      next_cycle();
      set_ctl(1'b0, 3'd0, mask);
      next_cycle();
      walk_channels(name, mask, stall);
   endtask

   // ------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------

   task automatic test_reset();
      for (int ch = 0; ch < NCH; ch++)
      begin
         check_bit("test_reset", 1'b0, scrb_awvalid[ch]);
         check_bit("test_reset", 1'b0, scrb_done[ch]);
      end
      check_bit("test_reset", 1'b0, flr_done_w);
      check_word("test_reset", `CL_SH_ID0, id0);
      check_word("test_reset", `CL_SH_ID1, id1);
      finish_test("test_reset");
   endtask

   task automatic test_single_scrub();
      run_scrub("test_single_scrub", 4'b0100, 1'b1);
      finish_test("test_single_scrub");
   endtask

   task automatic test_all_channels();
      run_scrub("test_all_channels", 4'b1111, 1'b1);
      finish_test("test_all_channels");
   endtask

   task automatic test_debug_readback();
      scrb_addr_u fin;
      scrb_addr_u exp_addr;
      fin.addr = FINAL_ADDR;
      // Channel 1 rewinds to zero so each select reads a telling value
      set_ctl(1'b0, 3'd0, 4'b1101);
      next_cycle();
      next_cycle();
      for (int sel = 0; sel < 4; sel++)
      begin
         exp_addr.addr = (sel == 1) ? 64'd0 : FINAL_ADDR;
         set_ctl(1'b1, mem_sel_t'(sel), 4'b1101);
         next_cycle();
         next_cycle();
         check_word("test_debug_readback", exp_addr.half.lo, id0);
         check_word("test_debug_readback", exp_addr.half.hi, id1);
      end
      // Out of range select falls back to channel 0, not channel 1
      set_ctl(1'b1, 3'd5, 4'b1101);
      next_cycle();
      next_cycle();
      check_word("test_debug_readback", fin.half.lo, id0);
      check_word("test_debug_readback", fin.half.hi, id1);
      set_ctl(1'b0, 3'd0, 4'b1101);
      next_cycle();
      next_cycle();
      check_word("test_debug_readback", `CL_SH_ID0, id0);
      check_word("test_debug_readback", `CL_SH_ID1, id1);
      finish_test("test_debug_readback");
   endtask

   // Channel 3 is dropped here, channel 1 is already rewound
   task automatic test_disable_clears();
      set_ctl(1'b1, 3'd3, 4'b0101);
      next_cycle();
      next_cycle();
      check_bit("test_disable_clears", 1'b0, scrb_done[3]);
      check_bit("test_disable_clears", 1'b0, scrb_awvalid[3]);
      check_addr("test_disable_clears", scrb_addr_u'(64'd0), scrb_awaddr[3]);
      check_bit("test_disable_clears", 1'b1, scrb_done[0]);
      next_cycle();
      check_word("test_disable_clears", 32'd0, id0);
      check_word("test_disable_clears", 32'd0, id1);
      set_ctl(1'b0, 3'd0, 4'b1111);
      next_cycle();
      walk_channels("test_disable_clears", 4'b1010, 1'b0);
      finish_test("test_disable_clears");
   endtask

   // Single request cycle, done expected on the second edge only
   task automatic test_flr();
      flr_assert = 1'b1;
      next_cycle();
      flr_assert = 1'b0;
      check_bit("test_flr", 1'b0, flr_done_w);
      next_cycle();
      check_bit("test_flr", 1'b1, flr_done_w);
      next_cycle();
      check_bit("test_flr", 1'b0, flr_done_w);
      next_cycle();
      check_bit("test_flr", 1'b0, flr_done_w);
      finish_test("test_flr");
   endtask

   // ------------------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------------------

   initial
   begin
      rst_main_n   = 1'b0;
      flr_assert   = 1'b0;
      ctl0         = '0;
      scrb_awready = '0;
      rng_state    = 32'd1812;
      checks       = 0;
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_bad    = 0;
      repeat (2) @(posedge clk);
      #10;
      rst_main_n = 1'b1;
      repeat (10) next_cycle();
      test_reset();
      test_single_scrub();
      test_all_channels();
      test_debug_readback();
      test_disable_clears();
      test_flr();
      $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_bad, checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
      $display("test failed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+hw
hw/cl_scrub_pkg.sv
hw/cl_ctl_in.sv
hw/ddr_scrubber.sv
hw/scrub_id_readback.sv
hw/cl_scrub_top.sv
dv/tb_clk_gen.sv
dv/cl_scrub_properties.sv
dv/cl_scrub_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f verilog.f --top-module cl_scrub_tb

sim_out=$(./obj_dir/Vcl_scrub_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "test passed"; then
   exit 0
fi
exit 1
